// File: Bender.yml
package:
  name: mfu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mfu_pkg.sv
      - rtl/mfu_operand_stage.sv
      - rtl/mfu_lane.sv
      - rtl/mfu_result_stage.sv
      - rtl/mfu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/mfu_chk.sv
      - bench/mfu_monitor.sv
      - bench/mfu_tb.sv

// File: bench/mfu_chk.sv
`timescale 1ns/1ps

`include "mfu_config.svh"

module mfu_chk import mfu_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic in_data_available,
    input  vec_t out_data,
    input  logic out_data_available
);

    // Failure count, read by the testbench at the end of the run
    int assert_fails;

    // Output strobe held low once a reset edge has been seen
    a_quiet_in_reset: assert property (@(posedge clk) !reset |=> !out_data_available)
        else begin
            assert_fails++;
            $error("out_data_available high after a reset edge");
        end

    // Every output strobe traces back to a request MFU_LATENCY edges earlier
    a_latency: assert property (@(posedge clk) disable iff (!reset)
        out_data_available |-> $past(in_data_available, `MFU_LATENCY))
        else begin
            assert_fails++;
            $error("out_data_available without a request MFU_LATENCY cycles before");
        end

    // Result register holds between strobes
    a_hold: assert property (@(posedge clk) disable iff (!reset)
        !out_data_available |-> $stable(out_data))
        else begin
            assert_fails++;
            $error("out_data changed while out_data_available was low");
        end

endmodule

// File: bench/mfu_monitor.sv
`timescale 1ns/1ps

`include "mfu_config.svh"

module mfu_monitor import mfu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_data_available,
    input  mfu_op_e                    operation,
    input  act_kind_e                  activation_type,
    input  vec_t                       primary_inp,
    input  logic [`MFU_VRF_AWIDTH-1:0] vrf_read_addr,
    input  logic                       vrf_write_en,
    input  logic [`MFU_VRF_AWIDTH-1:0] vrf_write_addr,
    input  vec_t                       vrf_write_data,
    input  vec_t                       out_data,
    input  logic                       out_data_available,
    output int                         value_errors,
    output int                         strobe_errors,
    output int                         pending
);

    // Register file model, writes land after the read of the same cycle
    vec_t   vrf_model [`MFU_VRF_DEPTH];

    // Outstanding requests in issue order
    vec_t   exp_q [$];
    string  name_q [$];
    longint due_q [$];

    longint cycle;
    bit     seen_strobe;
    vec_t   exp_vec;
    string  exp_name;
    longint exp_due;

    // Piecewise-linear tanh, odd symmetric around zero
    function automatic elem_t tanh_ref(input elem_t x);
        int v;
        int mag;
        int slope;
        int icpt;
        v   = x;
        mag = (v < 0) ? -v : v;
        if (mag >= 90) begin
            slope = 0;
            icpt  = 127;
        end else if (mag >= 39) begin
            slope = 0;
            icpt  = 99;
        end else if (mag >= 28) begin
            slope = 2;
            icpt  = 46;
        end else if (mag >= 16) begin
            slope = 3;
            icpt  = 18;
        end else if (mag >= 1) begin
            slope = 4;
            icpt  = 0;
        end else begin
            slope = 0;
            icpt  = 0;
        end
        if (v < 0) begin
            icpt = -icpt;
        end
        return elem_t'(slope * v + icpt);
    endfunction

    // Expected vector, integer arithmetic then wrap to 8 bits
    function automatic vec_t expected_vec(input mfu_op_e op, input act_kind_e act,
                                          input vec_t a, input vec_t b);
        vec_t r;
        for (int i = 0; i < `MFU_NUM_LANES; i++) begin
            case (op)
                op_add: r[i] = elem_t'(int'(a[i]) + int'(b[i]));
                op_mul: r[i] = elem_t'(int'(a[i]) * int'(b[i]));
                op_activation: begin
                    if (act == act_tanh) begin
                        r[i] = tanh_ref(a[i]);
                    end else begin
                        r[i] = (a[i] < 0) ? elem_t'(0) : a[i];
                    end
                end
                default: r[i] = a[i];
            endcase
        end
        return r;
    endfunction

    function automatic string op_name(input mfu_op_e op, input act_kind_e act);
        case (op)
            op_add:        return "add";
            op_mul:        return "mul";
            op_activation: return (act == act_tanh) ? "tanh" : "relu";
            default:       return "bypass";
        endcase
    endfunction

    // Sampled at the falling edge, inputs and outputs are both settled there
    always @(negedge clk) begin
        cycle++;
        if (!reset) begin
            exp_q.delete();
            name_q.delete();
            due_q.delete();
            seen_strobe = 1'b0;
        end else begin
            // Output side first
            if (out_data_available) begin
                if (exp_q.size() == 0) begin
                    strobe_errors++;
                    $display("Output strobe at cycle %0d with no request outstanding", cycle);
                end else begin
                    exp_vec  = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    exp_due  = due_q.pop_front();
                    if (exp_due != cycle) begin
                        strobe_errors++;
                        $display("Result for %s came at cycle %0d but was due at cycle %0d",
                                 exp_name, cycle, exp_due);
                    end
                    if (out_data !== exp_vec) begin
                        value_errors++;
                        $display("Error %s: expected %h actual %h", exp_name, exp_vec, out_data);
                    end
                end
            end else if (due_q.size() != 0 && due_q[0] < cycle) begin
                strobe_errors++;
                $display("Result for %s never came, it was due at cycle %0d", name_q[0], due_q[0]);
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                void'(due_q.pop_front());
            end
            // Quiet output until the first request
            if (!seen_strobe && out_data !== '0) begin
                value_errors++;
                $display("Error after_reset: expected %h actual %h", vec_t'('0), out_data);
            end
            // Request side, read sees the contents before this cycle's write
            if (in_data_available) begin
                exp_q.push_back(expected_vec(operation, activation_type, primary_inp,
                                             vrf_model[vrf_read_addr]));
                name_q.push_back(op_name(operation, activation_type));
                // Strobe sampled at the next edge, result seen MFU_LATENCY falling edges on
                due_q.push_back(cycle + `MFU_LATENCY);
                seen_strobe = 1'b1;
            end
            if (vrf_write_en) begin
                vrf_model[vrf_write_addr] = vrf_write_data;
            end
        end
        pending = exp_q.size();
    end

endmodule

// File: bench/mfu_tb.sv
`timescale 1ns/1ps

`include "mfu_config.svh"

module mfu_tb import mfu_pkg::*; ();

    logic                       clk;
    logic                       reset;
    logic                       in_data_available;
    mfu_op_e                    operation;
    act_kind_e                  activation_type;
    vec_t                       primary_inp;
    logic [`MFU_VRF_AWIDTH-1:0] vrf_read_addr;
    logic                       vrf_write_en;
    logic [`MFU_VRF_AWIDTH-1:0] vrf_write_addr;
    vec_t                       vrf_write_data;
    vec_t                       out_data;
    logic                       out_data_available;

    int value_errors;
    int strobe_errors;
    int pending;
    int timeouts;

    // Galois LFSR state, x^16 + x^14 + x^13 + x^11 + 1
    logic [15:0] lfsr_state = 16'd17;

    // Boundary inputs for the activation segments
    int bounds [16] = '{1, -1, 15, -15, 16, -16, 28, -28,
                        39, -39, 90, -90, 0, 127, -128, 89};

    mfu_top DUT (.*);

    mfu_monitor u_monitor (.*);

    bind mfu_top mfu_chk u_chk (
        .clk                (clk),
        .reset              (reset),
        .in_data_available  (in_data_available),
        .out_data           (out_data),
        .out_data_available (out_data_available)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One LFSR step per bit, LSB shifted into the result
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic vec_t rand_vec();
        return vec_t'(take_bits(32));
    endfunction

    function automatic logic [`MFU_VRF_AWIDTH-1:0] rand_addr();
        return `MFU_VRF_AWIDTH'(take_bits(`MFU_VRF_AWIDTH));
    endfunction

    function automatic act_kind_e rand_act();
        return (take_bits(1) == 32'd1) ? act_tanh : act_relu;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Request for one cycle, write port left as the caller set it
    task automatic issue(input mfu_op_e op, input act_kind_e act, input vec_t vec,
                         input logic [`MFU_VRF_AWIDTH-1:0] addr);
        in_data_available = 1'b1;
        operation         = op;
        activation_type   = act;
        primary_inp       = vec;
        vrf_read_addr     = addr;
        tick();
    endtask

    task automatic go_idle();
        in_data_available = 1'b0;
        vrf_write_en      = 1'b0;
        tick();
    endtask

    task automatic write_vrf(input logic [`MFU_VRF_AWIDTH-1:0] addr, input vec_t data);
        in_data_available = 1'b0;
        vrf_write_en      = 1'b1;
        vrf_write_addr    = addr;
        vrf_write_data    = data;
        tick();
    endtask

    // Wait until the monitor has no request outstanding
    task automatic drain(input string phase);
        int waited;
        waited = 0;
        while (pending != 0 && waited < 100) begin
            tick();
            waited++;
        end
        if (pending != 0) begin
            timeouts++;
            $display("Timed out waiting for %s results, %0d still outstanding", phase, pending);
        end
    endtask

    initial begin : main_seq
        vec_t                       v;
        logic [`MFU_VRF_AWIDTH-1:0] a;
        int                         total;
        reset             = 1'b0;
        in_data_available = 1'b0;
        operation         = op_bypass;
        activation_type   = act_relu;
        primary_inp       = '0;
        vrf_read_addr     = '0;
        vrf_write_en      = 1'b0;
        vrf_write_addr    = '0;
        vrf_write_data    = '0;
        repeat (8) tick();
        reset = 1'b1;
        // Idle after reset, monitor expects zero output
        repeat (10) tick();
        // Fill every register-file entry
        for (int i = 0; i < `MFU_VRF_DEPTH; i++) begin
            write_vrf(`MFU_VRF_AWIDTH'(i), rand_vec());
        end
        go_idle();
        // Add and multiply with random writes alongside
        repeat (60) begin
            vrf_write_en   = (take_bits(1) == 32'd1);
            vrf_write_addr = rand_addr();
            vrf_write_data = rand_vec();
            issue((take_bits(1) == 32'd1) ? op_mul : op_add, act_relu, rand_vec(), rand_addr());
            if (take_bits(1) == 32'd1) begin
                go_idle();
            end
        end
        go_idle();
        drain("add and mul");
        // Activations on random data, then on the segment edges
        repeat (40) issue(op_activation, rand_act(), rand_vec(), rand_addr());
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < `MFU_NUM_LANES; j++) begin
                v[j] = elem_t'(bounds[4 * k + j]);
            end
            issue(op_activation, act_relu, v, '0);
            issue(op_activation, act_tanh, v, '0);
        end
        go_idle();
        drain("activation");
        repeat (20) issue(op_bypass, rand_act(), rand_vec(), rand_addr());
        go_idle();
        drain("bypass");
        // Back-to-back burst, any operation
        repeat (64) issue(mfu_op_e'(2'(take_bits(2))), rand_act(), rand_vec(), rand_addr());
        go_idle();
        drain("burst");
        // Write and read the same entry in one cycle, then read it again
        repeat (8) begin
            a              = rand_addr();
            vrf_write_en   = 1'b1;
            vrf_write_addr = a;
            vrf_write_data = rand_vec();
            issue((take_bits(1) == 32'd1) ? op_mul : op_add, act_relu, rand_vec(), a);
            vrf_write_en = 1'b0;
            issue(op_add, act_relu, rand_vec(), a);
        end
        go_idle();
        drain("read during write");
        repeat (4) tick();
        total = value_errors + strobe_errors + timeouts + DUT.u_chk.assert_fails;
        $display("Value errors %0d, strobe errors %0d, timeouts %0d, assertion failures %0d",
                 value_errors, strobe_errors, timeouts, DUT.u_chk.assert_fails);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/mfu_pkg.sv
rtl/mfu_operand_stage.sv
rtl/mfu_lane.sv
rtl/mfu_result_stage.sv
rtl/mfu_top.sv
bench/mfu_chk.sv
bench/mfu_monitor.sv
bench/mfu_tb.sv

// File: rtl/mfu_config.svh
`ifndef MFU_CONFIG_SVH
`define MFU_CONFIG_SVH

// Elements carried by one vector
`define MFU_NUM_LANES 4

// Signed element width
`define MFU_DATA_WIDTH 8

// Vector register file geometry
`define MFU_VRF_DEPTH 16
`define MFU_VRF_AWIDTH 4

// Edges from a sampled strobe to out_data_available
// Operand stage 1, lanes 2, result stage 1
`define MFU_LATENCY 4

`endif

// File: rtl/mfu_lane.sv
`timescale 1ns/1ps

module mfu_lane import mfu_pkg::*; (
    input  logic      clk,
    input  mfu_op_e   stage_op,
    input  act_kind_e stage_act_kind,
    input  elem_t     primary,
    input  elem_t     secondary,
    output elem_t     result
);

    // tanh segment lookup, y = slope * x + intercept
    elem_t tanh_slope;
    elem_t tanh_intercept;

    // Stage one combinational result
    elem_t stage_one_value;
    elem_t stage_one_intercept;

    // Stage one registers
    elem_t s1_value;
    elem_t s1_intercept;

    // Segment table, searched from the top of the range downwards
    always_comb begin
        if (primary >= 90) begin
            tanh_slope     = elem_t'(0);
            tanh_intercept = elem_t'(127);
        end else if (primary >= 39) begin
            tanh_slope     = elem_t'(0);
            tanh_intercept = elem_t'(99);
        end else if (primary >= 28) begin
            tanh_slope     = elem_t'(2);
            tanh_intercept = elem_t'(46);
        end else if (primary >= 16) begin
            tanh_slope     = elem_t'(3);
            tanh_intercept = elem_t'(18);
        end else if (primary >= 1) begin
            tanh_slope     = elem_t'(4);
            tanh_intercept = elem_t'(0);
        end else if (primary == 0) begin
            tanh_slope     = elem_t'(0);
            tanh_intercept = elem_t'(0);
        end else if (primary >= -15) begin
            tanh_slope     = elem_t'(4);
            tanh_intercept = elem_t'(0);
        end else if (primary >= -27) begin
            tanh_slope     = elem_t'(3);
            tanh_intercept = elem_t'(-18);
        end else if (primary >= -38) begin
            tanh_slope     = elem_t'(2);
            tanh_intercept = elem_t'(-46);
        end else if (primary >= -89) begin
            tanh_slope     = elem_t'(0);
            tanh_intercept = elem_t'(-99);
        end else begin
            // Saturated negative end, includes -128
            tanh_slope     = elem_t'(0);
            tanh_intercept = elem_t'(-127);
        end
    end

    // Stage one operation select
    // Intercept stays zero except for tanh, so stage two is a plain carry
    always_comb begin
        stage_one_value     = primary;
        stage_one_intercept = elem_t'(0);
        case (stage_op)
            op_add: begin
                // Wraps at 8 bits
                stage_one_value = primary + secondary;
            end
            op_mul: begin
                // Low 8 bits of the product
                stage_one_value = primary * secondary;
            end
            op_activation: begin
                if (stage_act_kind == act_tanh) begin
                    stage_one_value     = tanh_slope * primary;
                    stage_one_intercept = tanh_intercept;
                end else begin
                    // ReLU, sign bit decides
                    stage_one_value = primary[$bits(elem_t)-1] ? elem_t'(0) : primary;
                end
            end
            default: begin
                // Bypass
                stage_one_value = primary;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        s1_value     <= stage_one_value;
        s1_intercept <= stage_one_intercept;
    end

    // Stage two, intercept add for tanh
    always_ff @(posedge clk) begin
        result <= s1_value + s1_intercept;
    end

endmodule

// File: rtl/mfu_operand_stage.sv
`timescale 1ns/1ps

`include "mfu_config.svh"

module mfu_operand_stage import mfu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_data_available,
    input  mfu_op_e                    operation,
    input  act_kind_e                  activation_type,
    input  vec_t                       primary_inp,
    input  logic [`MFU_VRF_AWIDTH-1:0] vrf_read_addr,
    input  logic                       vrf_write_en,
    input  logic [`MFU_VRF_AWIDTH-1:0] vrf_write_addr,
    input  vec_t                       vrf_write_data,
    output logic                       stage_valid,
    output mfu_op_e                    stage_op,
    output act_kind_e                  stage_act_kind,
    output vec_t                       stage_primary,
    output vec_t                       stage_secondary
);

    // Single register file, shared by add and multiply
    vec_t vrf_mem [`MFU_VRF_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (vrf_write_en) begin
            vrf_mem[vrf_write_addr] <= vrf_write_data;
        end
    end

    // Synchronous read port
    // Same-address write in this cycle is not visible yet, old word comes out
    always_ff @(posedge clk) begin
        stage_secondary <= vrf_mem[vrf_read_addr];
    end

    // Operand capture, every cycle
    // Lanes only look at it when the matching valid travels alongside
    always_ff @(posedge clk) begin
        stage_primary  <= primary_inp;
        stage_op       <= operation;
        stage_act_kind <= activation_type;
    end

    // Strobe register, start of the valid chain
    always_ff @(posedge clk) begin
        if (!reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_data_available;
        end
    end

endmodule

// File: rtl/mfu_pkg.sv
`include "mfu_config.svh"

package mfu_pkg;

    // Operation select, encoding kept from the older MFU
    typedef enum logic [1:0] {
        op_activation = 2'd0,
        op_add        = 2'd1,
        op_mul        = 2'd2,
        op_bypass     = 2'd3
    } mfu_op_e;

    // Activation function for op_activation
    typedef enum logic {
        act_relu = 1'b0,
        act_tanh = 1'b1
    } act_kind_e;

    // One signed vector element
    typedef logic signed [`MFU_DATA_WIDTH-1:0] elem_t;

    // Full vector, lane 0 sits in the low bits
    typedef elem_t [`MFU_NUM_LANES-1:0] vec_t;

endpackage

// File: rtl/mfu_result_stage.sv
`timescale 1ns/1ps

module mfu_result_stage import mfu_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic stage_valid,
    input  vec_t lane_results,
    output vec_t out_data,
    output logic out_data_available
);

    // Valid shadow of the two lane stages
    logic [1:0] valid_dly;

    always_ff @(posedge clk) begin
        if (!reset) begin
            valid_dly <= 2'b00;
        end else begin
            valid_dly <= {valid_dly[0], stage_valid};
        end
    end

    // Output register, holds between strobes
    always_ff @(posedge clk) begin
        if (!reset) begin
            out_data           <= '0;
            out_data_available <= 1'b0;
        end else begin
            out_data_available <= valid_dly[1];
            if (valid_dly[1]) begin
                out_data <= lane_results;
            end
        end
    end

endmodule

// File: rtl/mfu_top.sv
`timescale 1ns/1ps

`include "mfu_config.svh"

module mfu_top import mfu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_data_available,
    input  mfu_op_e                    operation,
    input  act_kind_e                  activation_type,
    input  vec_t                       primary_inp,
    input  logic [`MFU_VRF_AWIDTH-1:0] vrf_read_addr,
    input  logic                       vrf_write_en,
    input  logic [`MFU_VRF_AWIDTH-1:0] vrf_write_addr,
    input  vec_t                       vrf_write_data,
    output vec_t                       out_data,
    output logic                       out_data_available
);

    // Operand stage outputs
    logic      stage_valid;
    mfu_op_e   stage_op;
    act_kind_e stage_act_kind;
    vec_t      stage_primary;
    vec_t      stage_secondary;

    // Gathered lane outputs
    vec_t      lane_results;

    mfu_operand_stage u_operand_stage (
        .clk               (clk),
        .reset             (reset),
        .in_data_available (in_data_available),
        .operation         (operation),
        .activation_type   (activation_type),
        .primary_inp       (primary_inp),
        .vrf_read_addr     (vrf_read_addr),
        .vrf_write_en      (vrf_write_en),
        .vrf_write_addr    (vrf_write_addr),
        .vrf_write_data    (vrf_write_data),
        .stage_valid       (stage_valid),
        .stage_op          (stage_op),
        .stage_act_kind    (stage_act_kind),
        .stage_primary     (stage_primary),
        .stage_secondary   (stage_secondary)
    );

    // One lane per element, op and activation kind shared
    for (genvar i = 0; i < `MFU_NUM_LANES; i++) begin : g_lane
        mfu_lane u_lane (
            .clk            (clk),
            .stage_op       (stage_op),
            .stage_act_kind (stage_act_kind),
            .primary        (stage_primary[i]),
            .secondary      (stage_secondary[i]),
            .result         (lane_results[i])
        );
    end

    mfu_result_stage u_result_stage (
        .clk                (clk),
        .reset              (reset),
        .stage_valid        (stage_valid),
        .lane_results       (lane_results),
        .out_data           (out_data),
        .out_data_available (out_data_available)
    );

endmodule
